// ==== Bender.yml ====
package:
  name: rcn_link

sources:
  # Package first, the rest depends on it
  - design/rcn_link_pkg.sv
  - design/rcn_fifo_async.sv
  - design/rcn_link_pack.sv
  - design/rcn_link_merge.sv
  - design/rcn_link_top.sv

  - target: test
    files:
      - testbench/rcn_link_tb.sv

// ==== all.f ====
design/rcn_link_pkg.sv
design/rcn_fifo_async.sv
design/rcn_link_pack.sv
design/rcn_link_merge.sv
design/rcn_link_top.sv
testbench/rcn_link_tb.sv

// ==== design/rcn_fifo_async.sv ====
`timescale 1ns/1ps

module rcn_fifo_async
#(
    parameter type payload_t = rcn_link_pkg::byte_t
)
(
    input  logic clk_in,
    input  logic clk_out,
    input  logic rst_in,

    input  payload_t din,
    input  logic push,
    output logic full,

    output payload_t dout,
    input  logic pop,
    output logic empty
);

    import rcn_link_pkg::*;

    // Token walks 00 -> 01 -> 11 -> 10 -> 00, one bit per step
    function automatic logic [1:0] token_succ(input logic [1:0] tok);
        logic [1:0] nxt;
        case (tok)
            2'b00: nxt = 2'b01;
            2'b01: nxt = 2'b11;
            2'b11: nxt = 2'b10;
            default: nxt = 2'b00;
        endcase
        return nxt;
    endfunction

    logic [1:0] tok_in;         // clk_in copy of token
    logic [1:0] tok_in_sync;    // Token back in clk_out
    logic [1:0] tok_out;

    logic [FIFO_ADDR_W-1:0] head_in;
    logic [FIFO_ADDR_W-1:0] head_in_next;
    logic [FIFO_ADDR_W-1:0] head_snapshot;
    logic [FIFO_ADDR_W-1:0] tail_in;

    logic [FIFO_ADDR_W-1:0] tail_out;
    logic [FIFO_ADDR_W-1:0] tail_out_next;
    logic [FIFO_ADDR_W-1:0] tail_snapshot;
    logic [FIFO_ADDR_W-1:0] head_out;

    payload_t mem [FIFO_DEPTH];

    always_ff @(posedge clk_in or posedge rst_in)
    begin
        if (rst_in)
            tok_in <= 2'b00;
        else
            tok_in <= tok_out;
    end

    always_ff @(posedge clk_out or posedge rst_in)
    begin
        if (rst_in)
        begin
            tok_in_sync <= 2'b00;
            tok_out <= 2'b00;
        end
        else
        begin
            tok_in_sync <= tok_in;
            tok_out <= token_succ(tok_in_sync);    // Advance once the copy came back
        end
    end

    // Write side
    assign head_in_next = head_in + 1'b1;
    assign full = (head_in_next == tail_in);

    always_ff @(posedge clk_in or posedge rst_in)
    begin
        if (rst_in)
        begin
            head_in <= '0;
            head_snapshot <= '0;
            tail_in <= '0;
        end
        else
        begin
            if (push && !full)
                head_in <= head_in_next;

            if (tok_in == 2'b01)
                head_snapshot <= head_in;
            if (tok_in == 2'b10)
                tail_in <= tail_snapshot;   // Snapshot held stable by now
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (push && !full)
            mem[head_in] <= din;
    end

    // Read side, show-ahead
    assign tail_out_next = tail_out + 1'b1;
    assign empty = (tail_out == head_out);
    assign dout = mem[tail_out];

    always_ff @(posedge clk_out or posedge rst_in)
    begin
        if (rst_in)
        begin
            tail_out <= '0;
            tail_snapshot <= '0;
            head_out <= '0;
        end
        else
        begin
            if (pop && !empty)
                tail_out <= tail_out_next;

            if (tok_out == 2'b01)
                tail_snapshot <= tail_out;
            if (tok_out == 2'b10)
                head_out <= head_snapshot;
        end
    end

    a_no_pop_empty: assert property (
        @(posedge clk_out) disable iff (rst_in) pop |-> !empty
    );

    // Token holds or steps to its successor, never jumps
    a_token_step: assert property (
        @(posedge clk_out) disable iff (rst_in)
        (tok_out == $past(tok_out)) || (tok_out == token_succ($past(tok_out)))
    );

endmodule

// ==== design/rcn_link_merge.sv ====
`timescale 1ns/1ps

module rcn_link_merge
(
    input  logic clk_out,
    input  logic rst_in,

    input  logic drain_en,

    input  rcn_link_pkg::byte_t ev_dout,
    input  logic ev_empty,
    output logic ev_pop,

    input  rcn_link_pkg::msg_t msg_dout,
    input  logic msg_empty,
    output logic msg_pop,

    output logic out_valid,
    output rcn_link_pkg::src_t out_src,
    output rcn_link_pkg::msg_t out_data
);

    import rcn_link_pkg::*;

    src_t last_src;     // Source served most recently
    msg_t ev_word;

    // Event byte widened to the output word
    assign ev_word = {{($bits(msg_t) - $bits(byte_t)){1'b0}}, ev_dout};

    // Prefer the other source, fall back to the same one
    always_comb
    begin
        ev_pop = 1'b0;
        msg_pop = 1'b0;
        if (drain_en)
        begin
            if (last_src == SRC_MSG)
            begin
                if (!ev_empty)
                    ev_pop = 1'b1;
                else if (!msg_empty)
                    msg_pop = 1'b1;
            end
            else
            begin
                if (!msg_empty)
                    msg_pop = 1'b1;
                else if (!ev_empty)
                    ev_pop = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_out or posedge rst_in)
    begin
        if (rst_in)
        begin
            out_valid <= 1'b0;
            last_src <= SRC_MSG;    // Channel A goes first
        end
        else
        begin
            out_valid <= ev_pop || msg_pop;
            if (ev_pop)
                last_src <= SRC_EVENT;
            else if (msg_pop)
                last_src <= SRC_MSG;
        end
    end

    always_ff @(posedge clk_out)
    begin
        if (ev_pop)
        begin
            out_src <= SRC_EVENT;
            out_data <= ev_word;
        end
        else if (msg_pop)
        begin
            out_src <= SRC_MSG;
            out_data <= msg_dout;
        end
    end

    a_one_pop: assert property (
        @(posedge clk_out) disable iff (rst_in) !(ev_pop && msg_pop)
    );

    a_valid_drain: assert property (
        @(posedge clk_out) disable iff (rst_in) out_valid |-> $past(drain_en)
    );

endmodule

// ==== design/rcn_link_pack.sv ====
`timescale 1ns/1ps

module rcn_link_pack
(
    input  logic clk_in,
    input  logic rst_in,

    input  rcn_link_pkg::byte_t b_data,
    input  logic b_push,

    output rcn_link_pkg::msg_t pack_word,
    output logic pack_push
);

    import rcn_link_pkg::*;

    logic have_hi;      // First byte of the pair held
    byte_t hi_byte;

    always_ff @(posedge clk_in or posedge rst_in)
    begin
        if (rst_in)
        begin
            have_hi <= 1'b0;
            pack_push <= 1'b0;
        end
        else
        begin
            pack_push <= b_push && have_hi;
            if (b_push)
                have_hi <= !have_hi;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (b_push)
        begin
            if (have_hi)
                pack_word <= {hi_byte, b_data};
            else
                hi_byte <= b_data;
        end
    end

    // A completed word is always followed by a fresh first byte
    a_push_gap: assert property (
        @(posedge clk_in) disable iff (rst_in) pack_push |=> !pack_push
    );

endmodule

// ==== design/rcn_link_pkg.sv ====
package rcn_link_pkg;

    // Pointer width per FIFO, one slot always kept free
    localparam int FIFO_ADDR_W = 4;
    localparam int FIFO_DEPTH = 1 << FIFO_ADDR_W;

    typedef logic [7:0] byte_t;

    // First received byte sits in the high half
    typedef logic [15:0] msg_t;

    typedef enum logic
    {
        SRC_EVENT = 1'b0,   // Channel A
        SRC_MSG = 1'b1      // Channel B
    } src_t;

endpackage

// ==== design/rcn_link_top.sv ====
`timescale 1ns/1ps

module rcn_link_top
(
    input  logic clk_in,
    input  logic clk_out,
    input  logic rst_in,

    // Channel A, single events
    input  rcn_link_pkg::byte_t a_data,
    input  logic a_push,
    output logic a_full,

    // Channel B, bytes paired into messages
    input  rcn_link_pkg::byte_t b_data,
    input  logic b_push,
    output logic b_full,

    input  logic drain_en,

    output logic out_valid,
    output rcn_link_pkg::src_t out_src,
    output rcn_link_pkg::msg_t out_data
);

    import rcn_link_pkg::*;

    byte_t ev_dout;
    logic ev_empty;
    logic ev_pop;

    msg_t pack_word;
    logic pack_push;

    msg_t msg_dout;
    logic msg_empty;
    logic msg_pop;

    rcn_fifo_async #(.payload_t(byte_t)) ev_fifo_inst
    (
        .clk_in  (clk_in),
        .clk_out (clk_out),
        .rst_in  (rst_in),
        .din     (a_data),
        .push    (a_push),
        .full    (a_full),
        .dout    (ev_dout),
        .pop     (ev_pop),
        .empty   (ev_empty)
    );

    rcn_link_pack pack_inst
    (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .b_data    (b_data),
        .b_push    (b_push),
        .pack_word (pack_word),
        .pack_push (pack_push)
    );

    rcn_fifo_async #(.payload_t(msg_t)) msg_fifo_inst
    (
        .clk_in  (clk_in),
        .clk_out (clk_out),
        .rst_in  (rst_in),
        .din     (pack_word),
        .push    (pack_push),
        .full    (b_full),
        .dout    (msg_dout),
        .pop     (msg_pop),
        .empty   (msg_empty)
    );

    rcn_link_merge merge_inst
    (
        .clk_out   (clk_out),
        .rst_in    (rst_in),
        .drain_en  (drain_en),
        .ev_dout   (ev_dout),
        .ev_empty  (ev_empty),
        .ev_pop    (ev_pop),
        .msg_dout  (msg_dout),
        .msg_empty (msg_empty),
        .msg_pop   (msg_pop),
        .out_valid (out_valid),
        .out_src   (out_src),
        .out_data  (out_data)
    );

endmodule

// ==== testbench/rcn_link_tb.sv ====
`timescale 1ns/1ps

module rcn_link_tb;

    import rcn_link_pkg::*;

    localparam time CLK_IN_HALF = 4ns;
    localparam time CLK_OUT_HALF = 5ns;

    logic clk_in = 1'b0;
    logic clk_out = 1'b0;
    logic rst_in;
    byte_t a_data;
    logic a_push;
    logic a_full;
    byte_t b_data;
    logic b_push;
    logic b_full;
    logic drain_en;
    logic out_valid;
    src_t out_src;
    msg_t out_data;

    integer seed = 32'he1b7a257;
    string test_name = "reset";
    msg_t ev_exp[$];        // Expected channel A entries
    msg_t msg_exp[$];
    logic b_have_hi;        // Model of the pending first byte
    byte_t b_hi;
    logic alt_mode = 1'b0;
    src_t alt_expect;
    int drain_low_cycles = 0;
    logic [31:0] r;

    always #CLK_IN_HALF clk_in = ~clk_in;
    always #CLK_OUT_HALF clk_out = ~clk_out;

    rcn_link_top rcn_link_top_inst
    (
        .clk_in    (clk_in),
        .clk_out   (clk_out),
        .rst_in    (rst_in),
        .a_data    (a_data),
        .a_push    (a_push),
        .a_full    (a_full),
        .b_data    (b_data),
        .b_push    (b_push),
        .b_full    (b_full),
        .drain_en  (drain_en),
        .out_valid (out_valid),
        .out_src   (out_src),
        .out_data  (out_data)
    );

    // Event bytes widen with zeros, message pairs go high byte first
    function automatic msg_t expected_entry(input src_t src, input byte_t hi, input byte_t lo);
        if (src == SRC_EVENT)
            return {8'h00, lo};
        return {hi, lo};
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input msg_t exp, input msg_t act);
        if (act !== exp)
            stop_on_error($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_src(input string name, input src_t exp, input src_t act);
        if (act !== exp)
            stop_on_error($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic compare_output();
        msg_t exp;
        if (alt_mode)
        begin
            check_src({test_name, " alternation"}, alt_expect, out_src);
            alt_expect = (alt_expect == SRC_EVENT) ? SRC_MSG : SRC_EVENT;
        end
        if (out_src == SRC_EVENT)
        begin
            if (ev_exp.size() == 0)
                stop_on_error({test_name, ": event output seen with nothing expected"});
            exp = ev_exp.pop_front();
        end
        else
        begin
            if (msg_exp.size() == 0)
                stop_on_error({test_name, ": message output seen with nothing expected"});
            exp = msg_exp.pop_front();
        end
        check_word({test_name, " data"}, exp, out_data);
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk_out)
    begin
        if (rst_in)
            drain_low_cycles = 0;
        else
        begin
            if (drain_en)
                drain_low_cycles = 0;
            else
                drain_low_cycles++;
            if (drain_low_cycles >= 2)
                check_flag({test_name, " drain stop"}, 1'b0, out_valid);
            if (out_valid)
                compare_output();
        end
    end

    task automatic drive_cycle(input logic a_en, input byte_t a_val,
                               input logic b_en, input byte_t b_val);
        logic a_ok;
        logic b_ok;
        @(posedge clk_in);
        #1;
        a_ok = a_en && !a_full;
        b_ok = b_en && (!b_have_hi || !b_full);   // Only the second byte leads to a push
        a_push = a_ok;
        a_data = a_val;
        b_push = b_ok;
        b_data = b_val;
        if (a_ok)
            ev_exp.push_back(expected_entry(SRC_EVENT, 8'h00, a_val));
        if (b_ok && b_have_hi)
        begin
            msg_exp.push_back(expected_entry(SRC_MSG, b_hi, b_val));
            b_have_hi = 1'b0;
        end
        else if (b_ok)
        begin
            b_hi = b_val;
            b_have_hi = 1'b1;
        end
    endtask

    task automatic set_drain(input logic value);
        @(posedge clk_out);
        #1;
        drain_en = value;
    endtask

    task automatic apply_reset();
        rst_in = 1'b1;
        a_push = 1'b0;
        b_push = 1'b0;
        b_have_hi = 1'b0;
        repeat (5) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
    endtask

    // Queues only change at the falling edge
    task automatic wait_drained(input int limit);
        for (int i = 0; i < limit && (ev_exp.size() != 0 || msg_exp.size() != 0); i++)
            @(posedge clk_out);
        if (ev_exp.size() != 0 || msg_exp.size() != 0)
            stop_on_error({test_name, ": expected outputs still missing after timeout"});
    endtask

    task automatic wait_fulls_clear(input int limit);
        for (int i = 0; i < limit && (a_full || b_full); i++)
            @(negedge clk_in);
        if (a_full || b_full)
            stop_on_error({test_name, ": full flag stayed high after drain was enabled"});
    endtask

    task automatic random_traffic(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            r = $random(seed);
            drive_cycle(r[0], r[15:8], r[1], r[23:16]);
        end
    endtask

    initial
    begin
        a_data = '0;
        b_data = '0;
        drain_en = 1'b0;
        apply_reset();
        set_drain(1'b1);

        test_name = "event order";
        for (int i = 0; i < 60; i++)
        begin
            r = $random(seed);
            drive_cycle(r[0] | r[1], r[15:8], 1'b0, 8'h00);
        end
        drive_cycle(1'b0, 8'h00, 1'b0, 8'h00);
        wait_drained(500);

        test_name = "message packing";
        for (int i = 0; i < 80; i++)
            drive_cycle(1'b0, 8'h00, 1'b1, byte_t'($random(seed)));
        drive_cycle(1'b0, 8'h00, 1'b0, 8'h00);
        wait_drained(500);

        // Fresh pointers for exact full counts
        test_name = "full flags";
        set_drain(1'b0);
        apply_reset();
        for (int i = 0; i < 15; i++)
            drive_cycle(1'b1, byte_t'($random(seed)), 1'b0, 8'h00);
        check_flag("a_full after 14 pushes", 1'b0, a_full);
        drive_cycle(1'b0, 8'h00, 1'b0, 8'h00);
        check_flag("a_full after 15 pushes", 1'b1, a_full);
        for (int i = 0; i < 30; i++)
            drive_cycle(1'b0, 8'h00, 1'b1, byte_t'($random(seed)));
        drive_cycle(1'b0, 8'h00, 1'b0, 8'h00);
        check_flag("b_full after 30 bytes", 1'b0, b_full);
        drive_cycle(1'b0, 8'h00, 1'b0, 8'h00);
        check_flag("b_full after packer cycle", 1'b1, b_full);
        repeat (40) @(posedge clk_out);     // Past the snapshot latency

        test_name = "round robin";
        alt_expect = SRC_EVENT;
        alt_mode = 1'b1;
        set_drain(1'b1);
        wait_fulls_clear(200);
        wait_drained(500);
        alt_mode = 1'b0;

        test_name = "drain stop";
        fork
            random_traffic(400);
            begin
                @(posedge clk_out);
                repeat (12)
                begin
                    repeat (4 + ($random(seed) & 15)) @(posedge clk_out);
                    set_drain(!drain_en);
                end
            end
        join
        drive_cycle(1'b0, 8'h00, 1'b0, 8'h00);
        set_drain(1'b1);
        wait_drained(2000);
        repeat (100) @(posedge clk_out);    // Any extra output fails in the monitor

        $display("Verification passed");
        $finish;
    end

endmodule
